/* tag_dir_pkg.sv */
package tag_dir_pkg;

    // directory geometry
    localparam int LIST_DEPTH = 4;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 2;

    // line number inside the directory
    typedef logic [TAG_W-1:0]   tag_t;
    // tracked address index
    typedef logic [INDEX_W-1:0] index_t;
    // list length, needs to reach LIST_DEPTH
    typedef logic [TAG_W:0]     count_t;

    typedef enum logic [2:0] {
        CMD_READ    = 3'd0,
        CMD_WRITE   = 3'd1,
        CMD_ALLOC   = 3'd2,
        CMD_FILL    = 3'd3,
        CMD_RELEASE = 3'd4
    } cmd_e;

    typedef enum logic [1:0] {
        ST_INVALID = 2'd0,
        ST_FETCH   = 2'd1,
        ST_VALID   = 2'd2,
        ST_DIRTY   = 2'd3
    } line_state_e;

endpackage

/* tag_match.sv */
`timescale 1ns/1ps

module tag_match (
    input  tag_dir_pkg::index_t      index,
    input  tag_dir_pkg::line_state_e line_status [tag_dir_pkg::LIST_DEPTH],
    input  tag_dir_pkg::index_t      line_index  [tag_dir_pkg::LIST_DEPTH],
    output logic                     match_hit,
    output tag_dir_pkg::tag_t        match_tag
);
    import tag_dir_pkg::*;

    logic [LIST_DEPTH-1:0] line_hit;

    // one comparator per line, invalid lines never match
    always_comb begin
        for (int i = 0; i < LIST_DEPTH; i++) begin
            line_hit[i] = (line_status[i] != ST_INVALID) && (line_index[i] == index);
        end
    end

    // highest matching line wins
    always_comb begin
        match_tag = '0;
        for (int i = 0; i < LIST_DEPTH; i++) begin
            if (line_hit[i]) begin
                match_tag = tag_t'(i);
            end
        end
    end

    assign match_hit = |line_hit;

endmodule

/* line_state.sv */
`timescale 1ns/1ps

module line_state (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     set_state,
    input  tag_dir_pkg::tag_t        set_tag,
    input  tag_dir_pkg::line_state_e set_status,
    input  tag_dir_pkg::index_t      set_index,
    output tag_dir_pkg::line_state_e line_status [tag_dir_pkg::LIST_DEPTH],
    output tag_dir_pkg::index_t      line_index  [tag_dir_pkg::LIST_DEPTH]
);
    import tag_dir_pkg::*;

    line_state_e status_q [LIST_DEPTH];
    index_t      index_q  [LIST_DEPTH];
    logic [LIST_DEPTH-1:0] wr_en;

    // decode the written line
    always_comb begin
        for (int i = 0; i < LIST_DEPTH; i++) begin
            wr_en[i] = set_state && (set_tag == tag_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LIST_DEPTH; i++) begin
                status_q[i] <= ST_INVALID;
            end
        end else begin
            for (int i = 0; i < LIST_DEPTH; i++) begin
                if (wr_en[i]) begin
                    status_q[i] <= set_status;
                end
            end
        end
    end

    // index must read 0 on a free line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LIST_DEPTH; i++) begin
                index_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LIST_DEPTH; i++) begin
                if (wr_en[i]) begin
                    index_q[i] <= set_index;
                end
            end
        end
    end

    assign line_status = status_q;
    assign line_index  = index_q;

endmodule

/* lru_order.sv */
`timescale 1ns/1ps

module lru_order (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              touch,
    input  tag_dir_pkg::tag_t touch_tag,
    input  logic              take,
    input  tag_dir_pkg::tag_t take_tag,
    input  logic              take_from_free,
    input  logic              drop,
    input  tag_dir_pkg::tag_t drop_tag,
    output tag_dir_pkg::tag_t lru_tail,
    output tag_dir_pkg::tag_t free_tail,
    output logic              free_empty
);
    import tag_dir_pkg::*;

    // pointer table shared by both lists
    tag_t   pre_q [LIST_DEPTH];
    tag_t   nxt_q [LIST_DEPTH];
    tag_t   pre_d [LIST_DEPTH];
    tag_t   nxt_d [LIST_DEPTH];

    // slot 0 is the lru list, slot 1 the free list
    tag_t   head_q [2];
    tag_t   tail_q [2];
    count_t len_q  [2];
    tag_t   head_d [2];
    tag_t   tail_d [2];
    count_t len_d  [2];

    logic   move;
    tag_t   mv_tag;
    logic   src;
    logic   dst;

    // every strobe is an unlink from src followed by a head insert into dst
    always_comb begin
        move   = touch | take | drop;
        mv_tag = touch_tag;
        src    = 1'b0;
        dst    = 1'b0;
        if (take) begin
            mv_tag = take_tag;
            src    = take_from_free;
        end else if (drop) begin
            mv_tag = drop_tag;
            dst    = 1'b1;
        end
    end

    always_comb begin
        pre_d  = pre_q;
        nxt_d  = nxt_q;
        head_d = head_q;
        tail_d = tail_q;
        len_d  = len_q;
        if (move) begin
            // single element needs no pointer fixup
            if (len_d[src] != count_t'(1)) begin
                if (mv_tag == head_d[src]) begin
                    head_d[src] = nxt_d[mv_tag];
                end else if (mv_tag == tail_d[src]) begin
                    tail_d[src] = pre_d[mv_tag];
                end else begin
                    nxt_d[pre_d[mv_tag]] = nxt_d[mv_tag];
                    pre_d[nxt_d[mv_tag]] = pre_d[mv_tag];
                end
            end
            len_d[src] = len_d[src] - count_t'(1);

            if (len_d[dst] == '0) begin
                tail_d[dst] = mv_tag;
            end else begin
                nxt_d[mv_tag]      = head_d[dst];
                pre_d[head_d[dst]] = mv_tag;
            end
            head_d[dst] = mv_tag;
            len_d[dst]  = len_d[dst] + count_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // free list 0..N-1 as a ring, tail at the top line
            for (int i = 0; i < LIST_DEPTH; i++) begin
                pre_q[i] <= tag_t'(i - 1);
                nxt_q[i] <= tag_t'(i + 1);
            end
            head_q[0] <= '0;
            tail_q[0] <= '0;
            len_q[0]  <= '0;
            head_q[1] <= '0;
            tail_q[1] <= tag_t'(LIST_DEPTH - 1);
            len_q[1]  <= count_t'(LIST_DEPTH);
        end else begin
            pre_q  <= pre_d;
            nxt_q  <= nxt_d;
            head_q <= head_d;
            tail_q <= tail_d;
            len_q  <= len_d;
        end
    end

    assign lru_tail   = tail_q[0];
    assign free_tail  = tail_q[1];
    assign free_empty = (len_q[1] == '0);

endmodule

/* access_ctrl.sv */
`timescale 1ns/1ps

module access_ctrl (
    input  logic                     req,
    input  tag_dir_pkg::cmd_e        cmd,
    input  tag_dir_pkg::index_t      index,
    input  tag_dir_pkg::tag_t        tag,
    input  logic                     match_hit,
    input  tag_dir_pkg::tag_t        match_tag,
    input  tag_dir_pkg::line_state_e line_status [tag_dir_pkg::LIST_DEPTH],
    input  tag_dir_pkg::index_t      line_index  [tag_dir_pkg::LIST_DEPTH],
    input  tag_dir_pkg::tag_t        lru_tail,
    input  tag_dir_pkg::tag_t        free_tail,
    input  logic                     free_empty,
    output logic                     gnt,
    output logic                     hit,
    output tag_dir_pkg::tag_t        resp_tag,
    output tag_dir_pkg::line_state_e resp_status,
    output tag_dir_pkg::index_t      resp_index,
    output logic                     touch,
    output tag_dir_pkg::tag_t        touch_tag,
    output logic                     take,
    output tag_dir_pkg::tag_t        take_tag,
    output logic                     take_from_free,
    output logic                     drop,
    output tag_dir_pkg::tag_t        drop_tag,
    output logic                     set_state,
    output tag_dir_pkg::tag_t        set_tag,
    output tag_dir_pkg::line_state_e set_status,
    output tag_dir_pkg::index_t      set_index
);
    import tag_dir_pkg::*;

    logic acc;
    logic is_lookup;
    logic is_alloc;
    tag_t victim;

    assign is_lookup = (cmd == CMD_READ) || (cmd == CMD_WRITE);
    assign is_alloc  = (cmd == CMD_ALLOC);
    assign victim    = free_empty ? lru_tail : free_tail;

    // an lru victim still fetching cannot be evicted
    assign gnt = !(is_alloc && free_empty && (line_status[lru_tail] == ST_FETCH));
    assign acc = req && gnt;
    assign hit = acc && is_lookup && match_hit;

    // report the line as it was before this access
    always_comb begin
        resp_tag    = '0;
        resp_status = ST_INVALID;
        resp_index  = '0;
        if (hit) begin
            resp_tag    = match_tag;
            resp_status = line_status[match_tag];
            resp_index  = line_index[match_tag];
        end else if (acc && is_alloc) begin
            resp_tag    = victim;
            resp_status = line_status[victim];
            resp_index  = line_index[victim];
        end
    end

    assign touch          = hit;
    assign touch_tag      = match_tag;
    assign take           = acc && is_alloc;
    assign take_tag       = victim;
    assign take_from_free = !free_empty;
    assign drop           = acc && (cmd == CMD_RELEASE) && (line_status[tag] != ST_INVALID);
    assign drop_tag       = tag;

    always_comb begin
        set_state  = 1'b0;
        set_tag    = tag;
        set_status = ST_INVALID;
        set_index  = '0;
        if (acc) begin
            case (cmd)
                CMD_WRITE: begin
                    set_state  = match_hit && (line_status[match_tag] == ST_VALID);
                    set_tag    = match_tag;
                    set_status = ST_DIRTY;
                    set_index  = line_index[match_tag];
                end
                CMD_ALLOC: begin
                    set_state  = 1'b1;
                    set_tag    = victim;
                    set_status = ST_FETCH;
                    set_index  = index;
                end
                CMD_FILL: begin
                    set_state  = (line_status[tag] == ST_FETCH);
                    set_status = ST_VALID;
                    set_index  = line_index[tag];
                end
                CMD_RELEASE: begin
                    // index goes back to 0 with the invalid state
                    set_state  = (line_status[tag] != ST_INVALID);
                end
                default: begin
                    set_state = 1'b0;
                end
            endcase
        end
    end

endmodule

/* tag_dir_top.sv */
`timescale 1ns/1ps

module tag_dir_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  tag_dir_pkg::cmd_e        cmd,
    input  tag_dir_pkg::index_t      index,
    input  tag_dir_pkg::tag_t        tag,
    output logic                     gnt,
    output logic                     hit,
    output tag_dir_pkg::tag_t        resp_tag,
    output tag_dir_pkg::line_state_e resp_status,
    output tag_dir_pkg::index_t      resp_index
);
    import tag_dir_pkg::*;

    logic        match_hit;
    tag_t        match_tag;
    line_state_e line_status [LIST_DEPTH];
    index_t      line_index  [LIST_DEPTH];
    tag_t        lru_tail;
    tag_t        free_tail;
    logic        free_empty;

    // update strobes from the controller
    logic        touch;
    tag_t        touch_tag;
    logic        take;
    tag_t        take_tag;
    logic        take_from_free;
    logic        drop;
    tag_t        drop_tag;
    logic        set_state;
    tag_t        set_tag;
    line_state_e set_status;
    index_t      set_index;

    tag_match u_tag_match (
        .index       (index),
        .line_status (line_status),
        .line_index  (line_index),
        .match_hit   (match_hit),
        .match_tag   (match_tag)
    );

    line_state u_line_state (
        .clk         (clk),
        .rst_n       (rst_n),
        .set_state   (set_state),
        .set_tag     (set_tag),
        .set_status  (set_status),
        .set_index   (set_index),
        .line_status (line_status),
        .line_index  (line_index)
    );

    lru_order u_lru_order (
        .clk            (clk),
        .rst_n          (rst_n),
        .touch          (touch),
        .touch_tag      (touch_tag),
        .take           (take),
        .take_tag       (take_tag),
        .take_from_free (take_from_free),
        .drop           (drop),
        .drop_tag       (drop_tag),
        .lru_tail       (lru_tail),
        .free_tail      (free_tail),
        .free_empty     (free_empty)
    );

    access_ctrl u_access_ctrl (
        .req            (req),
        .cmd            (cmd),
        .index          (index),
        .tag            (tag),
        .match_hit      (match_hit),
        .match_tag      (match_tag),
        .line_status    (line_status),
        .line_index     (line_index),
        .lru_tail       (lru_tail),
        .free_tail      (free_tail),
        .free_empty     (free_empty),
        .gnt            (gnt),
        .hit            (hit),
        .resp_tag       (resp_tag),
        .resp_status    (resp_status),
        .resp_index     (resp_index),
        .touch          (touch),
        .touch_tag      (touch_tag),
        .take           (take),
        .take_tag       (take_tag),
        .take_from_free (take_from_free),
        .drop           (drop),
        .drop_tag       (drop_tag),
        .set_state      (set_state),
        .set_tag        (set_tag),
        .set_status     (set_status),
        .set_index      (set_index)
    );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     req,
    input tag_dir_pkg::cmd_e        cmd,
    input tag_dir_pkg::index_t      index,
    input tag_dir_pkg::tag_t        tag,
    input logic                     gnt,
    input logic                     hit,
    input tag_dir_pkg::tag_t        resp_tag,
    input tag_dir_pkg::line_state_e resp_status,
    input tag_dir_pkg::index_t      resp_index
);
    import tag_dir_pkg::*;

    // reference model of the directory
    line_state_e m_status [LIST_DEPTH];
    index_t      m_index  [LIST_DEPTH];
    // front of each queue is the list head
    tag_t        lru_list  [$];
    tag_t        free_list [$];

    // summary of the model for the stimulus side
    int          free_len;
    tag_t        lru_last;

    int          err_cnt = 0;
    int          chk_cnt = 0;

    task automatic compare(input string name, input int exp_val, input int act_val);
        chk_cnt++;
        if (exp_val != act_val) begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic reset_model();
        lru_list.delete();
        free_list.delete();
        for (int i = 0; i < LIST_DEPTH; i++) begin
            m_status[i] = ST_INVALID;
            m_index[i]  = '0;
            free_list.push_back(tag_t'(i));
        end
        free_len = LIST_DEPTH;
        lru_last = '0;
    endtask

    task automatic lru_remove(input tag_t t);
        for (int i = 0; i < lru_list.size(); i++) begin
            if (lru_list[i] == t) begin
                lru_list.delete(i);
                break;
            end
        end
    endtask

    task automatic check_cycle();
        logic        exp_gnt;
        logic        exp_hit;
        tag_t        exp_tag;
        line_state_e exp_status;
        index_t      exp_index;
        logic        found;
        tag_t        hit_tag;
        tag_t        victim;

        found   = 1'b0;
        hit_tag = '0;
        // highest line holding the index wins
        for (int i = 0; i < LIST_DEPTH; i++) begin
            if (m_status[i] != ST_INVALID && m_index[i] == index) begin
                found   = 1'b1;
                hit_tag = tag_t'(i);
            end
        end
        victim = '0;
        if (free_list.size() > 0) begin
            victim = free_list[$];
        end else if (lru_list.size() > 0) begin
            victim = lru_list[$];
        end
        exp_gnt = 1'b1;
        if (cmd == CMD_ALLOC && free_list.size() == 0 && m_status[victim] == ST_FETCH) begin
            exp_gnt = 1'b0;
        end
        compare("gnt", int'(exp_gnt), int'(gnt));

        if (req && exp_gnt) begin
            exp_hit    = 1'b0;
            exp_tag    = '0;
            exp_status = ST_INVALID;
            exp_index  = '0;
            case (cmd)
                CMD_READ, CMD_WRITE: begin
                    if (found) begin
                        exp_hit    = 1'b1;
                        exp_tag    = hit_tag;
                        exp_status = m_status[hit_tag];
                        exp_index  = m_index[hit_tag];
                        lru_remove(hit_tag);
                        lru_list.push_front(hit_tag);
                        if (cmd == CMD_WRITE && m_status[hit_tag] == ST_VALID) begin
                            m_status[hit_tag] = ST_DIRTY;
                        end
                    end
                end
                CMD_ALLOC: begin
                    exp_tag    = victim;
                    exp_status = m_status[victim];
                    exp_index  = m_index[victim];
                    if (free_list.size() > 0) begin
                        free_list.delete(free_list.size() - 1);
                    end else begin
                        lru_list.delete(lru_list.size() - 1);
                    end
                    lru_list.push_front(victim);
                    m_status[victim] = ST_FETCH;
                    m_index[victim]  = index;
                end
                CMD_FILL: begin
                    if (m_status[tag] == ST_FETCH) begin
                        m_status[tag] = ST_VALID;
                    end
                end
                CMD_RELEASE: begin
                    if (m_status[tag] != ST_INVALID) begin
                        m_status[tag] = ST_INVALID;
                        m_index[tag]  = '0;
                        lru_remove(tag);
                        free_list.push_front(tag);
                    end
                end
                default: begin
                end
            endcase
            compare("hit", int'(exp_hit), int'(hit));
            compare("resp_tag", int'(exp_tag), int'(resp_tag));
            compare("resp_status", int'(exp_status), int'(resp_status));
            compare("resp_index", int'(exp_index), int'(resp_index));
        end

        free_len = free_list.size();
        lru_last = '0;
        if (lru_list.size() > 0) begin
            lru_last = lru_list[$];
        end
    endtask

    // inputs change on the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            check_cycle();
        end
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import tag_dir_pkg::*;

    localparam int RAND_OPS    = 400;
    localparam int GNT_TIMEOUT = 50;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req;
    cmd_e        cmd;
    index_t      index;
    tag_t        tag;
    logic        gnt;
    logic        hit;
    tag_t        resp_tag;
    line_state_e resp_status;
    index_t      resp_index;

    logic [31:0] rand_state = 32'd53;
    int          timeout_cnt = 0;

    tag_dir_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .index       (index),
        .tag         (tag),
        .gnt         (gnt),
        .hit         (hit),
        .resp_tag    (resp_tag),
        .resp_status (resp_status),
        .resp_index  (resp_index)
    );

    tb_checker u_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .index       (index),
        .tag         (tag),
        .gnt         (gnt),
        .hit         (hit),
        .resp_tag    (resp_tag),
        .resp_status (resp_status),
        .resp_index  (resp_index)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // first index at or after start that no live line holds
    function automatic index_t absent_index(input index_t start);
        index_t cand;
        logic   used;
        cand = start;
        for (int n = 0; n < (1 << INDEX_W); n++) begin
            used = 1'b0;
            for (int i = 0; i < LIST_DEPTH; i++) begin
                if (u_chk.m_status[i] != ST_INVALID && u_chk.m_index[i] == cand) begin
                    used = 1'b1;
                end
            end
            if (!used) begin
                return cand;
            end
            cand = cand + index_t'(1);
        end
        return cand;
    endfunction

    task automatic apply_reset();
        rst_n <= 1'b0;
        req   <= 1'b0;
        cmd   <= CMD_READ;
        index <= '0;
        tag   <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    // called on a rising edge, returns on the edge that accepts the command
    task automatic issue(input cmd_e c, input index_t idx, input tag_t t);
        int waited;
        waited = 0;
        req   <= 1'b1;
        cmd   <= c;
        index <= idx;
        tag   <= t;
        @(negedge clk);
        while (!gnt && waited < GNT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!gnt) begin
            timeout_cnt++;
            $display("timeout: %s got no grant within %0d cycles", c.name(), waited);
        end
        @(posedge clk);
    endtask

    // command on the bus without a request
    task automatic hold_idle(input cmd_e c);
        req <= 1'b0;
        cmd <= c;
        @(posedge clk);
    endtask

    // request held for one cycle against a low gnt
    task automatic hold_blocked(input cmd_e c, input index_t idx);
        req   <= 1'b1;
        cmd   <= c;
        index <= idx;
        @(posedge clk);
    endtask

    task automatic alloc_unblocked(input index_t start);
        // a fetching lru tail must be filled before it can be evicted
        if (u_chk.free_len == 0 && u_chk.m_status[u_chk.lru_last] == ST_FETCH) begin
            issue(CMD_FILL, '0, u_chk.lru_last);
        end
        issue(CMD_ALLOC, absent_index(start), '0);
    endtask

    task automatic directed_tests();
        issue(CMD_READ, 4'h0, '0);
        issue(CMD_READ, 4'h5, '0);
        // free list hands out 3, 2, 1, 0
        issue(CMD_ALLOC, 4'h1, '0);
        issue(CMD_ALLOC, 4'h2, '0);
        issue(CMD_ALLOC, 4'h3, '0);
        issue(CMD_ALLOC, 4'h4, '0);
        issue(CMD_FILL, '0, 2'd3);
        issue(CMD_READ, 4'h1, '0);
        issue(CMD_WRITE, 4'h1, '0);
        issue(CMD_READ, 4'h1, '0);
        issue(CMD_FILL, '0, 2'd2);
        // lru tail is line 2 and valid
        issue(CMD_ALLOC, 4'h7, '0);
        // lru tail is line 1 and still fetching
        hold_blocked(CMD_ALLOC, 4'h8);
        hold_blocked(CMD_ALLOC, 4'h8);
        issue(CMD_FILL, '0, 2'd1);
        issue(CMD_ALLOC, 4'h8, '0);
        issue(CMD_FILL, '0, 2'd0);
        issue(CMD_ALLOC, 4'ha, '0);
        // dirty line 3 is evicted next
        issue(CMD_ALLOC, 4'h9, '0);
        issue(CMD_RELEASE, '0, 2'd2);
        issue(CMD_RELEASE, '0, 2'd0);
        issue(CMD_READ, 4'h7, '0);
        issue(CMD_ALLOC, 4'hb, '0);
        issue(CMD_ALLOC, 4'hc, '0);
    endtask

    task automatic random_op();
        logic [31:0] r;
        index_t      idx;
        r   = next_random();
        idx = r[19:16];
        // bias lookups toward indices that are tracked
        if (r[24]) begin
            idx = u_chk.m_index[r[21:20]];
        end
        case (r[27:25])
            3'd0, 3'd1: issue(CMD_READ, idx, '0);
            3'd2:       issue(CMD_WRITE, idx, '0);
            3'd3, 3'd4: alloc_unblocked(r[19:16]);
            3'd5, 3'd6: issue(CMD_FILL, '0, r[23:22]);
            default:    issue(CMD_RELEASE, '0, r[23:22]);
        endcase
    endtask

    initial begin
        apply_reset();
        directed_tests();
        for (int n = 0; n < RAND_OPS; n++) begin
            random_op();
        end
        hold_idle(CMD_READ);
        hold_idle(CMD_READ);
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 u_chk.chk_cnt, u_chk.err_cnt, timeout_cnt);
        if (u_chk.err_cnt == 0 && timeout_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
tag_dir_pkg.sv
tag_match.sv
line_state.sv
lru_order.sv
access_ctrl.sv
tag_dir_top.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the tag directory testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --top-module tb_top -Mdir "$OBJ" -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
